// File: src/spi_msg_pkg.sv
package spi_msg_pkg;

    // ==================================================
    // Message frame
    // ==================================================

    // Bits after the start bit, and bits in a response
    localparam int MSG_LEN      = 64;
    localparam int RESP_LEN     = 64;
    localparam int MSG_TYPE_LEN = 8;
    localparam int MSG_ARG_LEN  = MSG_LEN - MSG_TYPE_LEN;

    // Type codes with bit 7 set expect a response
    typedef enum logic [MSG_TYPE_LEN-1:0] {
        MSG_NOP                = 8'h00,
        MSG_LED_SET            = 8'h01,
        MSG_IMG_RESET          = 8'h02,
        MSG_IMG_SET_HEADER1    = 8'h03,
        MSG_IMG_SET_HEADER2    = 8'h04,
        MSG_IMG_CAPTURE        = 8'h05,
        MSG_ECHO               = 8'h80,
        MSG_IMG_CAPTURE_STATUS = 8'h81
    } msg_type_t;

    typedef logic [MSG_ARG_LEN-1:0] msg_arg_t;

    // Type occupies the top byte, first on the wire
    typedef struct packed {
        msg_type_t msg_type;
        msg_arg_t  arg;
    } msg_t;

    typedef logic [RESP_LEN-1:0] resp_t;

    // ==================================================
    // Peripheral registers
    // ==================================================
    typedef logic [3:0]   led_t;
    typedef logic [127:0] img_header_t;
    typedef logic [23:0]  word_count_t;

    // Header low bits are never written
    localparam int IMG_HDR_PAD = 16;

    // ImgCaptureStatus response layout
    localparam int STATUS_DONE_BIT  = 63;
    localparam int STATUS_COUNT_LSB = 32;

    // Single-cycle write strobes with the message argument
    typedef struct packed {
        logic     led_wr;
        logic     rst_wr;
        logic     hdr1_wr;
        logic     hdr2_wr;
        logic     capture;
        msg_arg_t arg;
    } reg_wr_t;

endpackage

// File: src/spi_msg_receiver.sv
`timescale 1ns/1ps

module spi_msg_receiver import spi_msg_pkg::*; (
    input  logic spi_clk,
    input  logic spi_rst_,
    input  logic spi_data_in,
    input  logic listen,
    output msg_t msg,
    output logic msg_valid
);

    typedef enum logic {
        RX_IDLE,
        RX_SHIFT
    } rx_state_t;

    localparam int CNT_W = $clog2(MSG_LEN);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(MSG_LEN - 1);

    rx_state_t          state;
    logic [CNT_W-1:0]   bit_cnt;
    logic [MSG_LEN-1:0] shift_q;

    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            state     <= RX_IDLE;
            bit_cnt   <= '0;
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    // First high bit on the line is the start bit
                    if (listen && spi_data_in) begin
                        state   <= RX_SHIFT;
                        bit_cnt <= '0;
                    end
                end
                RX_SHIFT: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == LAST_BIT) begin
                        state     <= RX_IDLE;
                        msg_valid <= 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // MSB first
    always_ff @(posedge spi_clk) begin
        if (state == RX_SHIFT) begin
            shift_q <= {shift_q[MSG_LEN-2:0], spi_data_in};
        end
    end

    assign msg = msg_t'(shift_q);

endmodule

// File: src/spi_resp_shifter.sv
`timescale 1ns/1ps

module spi_resp_shifter import spi_msg_pkg::*; (
    input  logic  spi_clk,
    input  logic  spi_rst_,
    input  resp_t resp,
    input  logic  resp_load,
    output logic  spi_data_out,
    output logic  spi_data_oe,
    output logic  resp_done
);

    localparam int CNT_W = $clog2(RESP_LEN);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(RESP_LEN - 1);

    logic [CNT_W-1:0]    bit_cnt;
    logic [RESP_LEN-1:0] shift_q;

    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            spi_data_oe <= 1'b0;
            bit_cnt     <= '0;
            resp_done   <= 1'b0;
        end else begin
            resp_done <= 1'b0;
            if (resp_load) begin
                spi_data_oe <= 1'b1;
                bit_cnt     <= LAST_BIT;
            end else if (spi_data_oe) begin
                if (bit_cnt == '0) begin
                    spi_data_oe <= 1'b0;
                    resp_done   <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt - 1'b1;
                end
            end
        end
    end

    // Zeros shift in behind the response and leave the line low
    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            shift_q <= '0;
        end else if (resp_load) begin
            shift_q <= resp;
        end else if (spi_data_oe) begin
            shift_q <= shift_q << 1;
        end
    end

    assign spi_data_out = shift_q[RESP_LEN-1];

endmodule

// File: src/img_cmd_regs.sv
`timescale 1ns/1ps

module img_cmd_regs import spi_msg_pkg::*; (
    input  logic        spi_clk,
    input  logic        spi_rst_,
    input  reg_wr_t     reg_wr,
    output led_t        led,
    output logic        img_rst_,
    output img_header_t img_header,
    output logic        capture_req
);

    // Upper and lower header words
    msg_arg_t hdr1_q;
    msg_arg_t hdr2_q;

    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            led         <= '0;
            img_rst_    <= 1'b0;
            hdr1_q      <= '0;
            hdr2_q      <= '0;
            capture_req <= 1'b0;
        end else begin
            if (reg_wr.led_wr) begin
                led <= reg_wr.arg[$bits(led_t)-1:0];
            end
            // Low holds the imager in reset
            if (reg_wr.rst_wr) begin
                img_rst_ <= reg_wr.arg[0];
            end
            if (reg_wr.hdr1_wr) begin
                hdr1_q <= reg_wr.arg;
            end
            if (reg_wr.hdr2_wr) begin
                hdr2_q <= reg_wr.arg;
            end
            // Capture request is a toggle into the imager domain
            if (reg_wr.capture) begin
                capture_req <= ~capture_req;
            end
        end
    end

    assign img_header = {hdr1_q, hdr2_q, {IMG_HDR_PAD{1'b0}}};

endmodule

// File: src/capture_done_flag.sv
`timescale 1ns/1ps

module capture_done_flag (
    input  logic spi_clk,
    input  logic spi_rst_,
    input  logic capture_done,
    input  logic ack,
    output logic capture_done_pending
);

    // Two-flop synchronizer for the done toggle
    logic [1:0] sync_q;
    logic       ack_q;

    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            sync_q <= '0;
            ack_q  <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], capture_done};
            // Only consume a pending event
            if (ack && capture_done_pending) begin
                ack_q <= ~ack_q;
            end
        end
    end

    // Pending while the toggles disagree
    assign capture_done_pending = sync_q[1] ^ ack_q;

endmodule

// File: src/spi_msg_ctrl.sv
`timescale 1ns/1ps

module spi_msg_ctrl import spi_msg_pkg::*; #(
    parameter int TURNAROUND_CYCLES = 6
) (
    input  logic        spi_clk,
    input  logic        spi_rst_,
    input  msg_t        msg,
    input  logic        msg_valid,
    input  logic        capture_done_pending,
    input  word_count_t capture_word_count,
    input  logic        resp_done,
    output logic        listen,
    output reg_wr_t     reg_wr,
    output resp_t       resp,
    output logic        resp_load
);

    typedef enum logic [1:0] {
        ST_LISTEN,
        ST_TURNAROUND,
        ST_RESPOND
    } ctrl_state_t;

    // Four bits hold up to 15 turnaround cycles
    localparam logic [3:0] TA_LAST = 4'(TURNAROUND_CYCLES - 1);

    ctrl_state_t state;
    logic [3:0]  ta_cnt;
    logic        has_resp;
    resp_t       resp_next;

    // ==================================================
    // Message decode
    // ==================================================
    always_comb begin
        reg_wr     = '0;
        reg_wr.arg = msg.arg;
        has_resp   = 1'b0;
        resp_next  = '0;
        case (msg.msg_type)
            MSG_LED_SET:         reg_wr.led_wr  = msg_valid;
            MSG_IMG_RESET:       reg_wr.rst_wr  = msg_valid;
            MSG_IMG_SET_HEADER1: reg_wr.hdr1_wr = msg_valid;
            MSG_IMG_SET_HEADER2: reg_wr.hdr2_wr = msg_valid;
            MSG_IMG_CAPTURE:     reg_wr.capture = msg_valid;
            MSG_ECHO: begin
                has_resp  = 1'b1;
                resp_next = {msg.arg, {(RESP_LEN - MSG_ARG_LEN){1'b0}}};
            end
            MSG_IMG_CAPTURE_STATUS: begin
                has_resp = 1'b1;
                resp_next[STATUS_DONE_BIT] = capture_done_pending;
                resp_next[STATUS_COUNT_LSB +: $bits(word_count_t)] = capture_word_count;
            end
            // Nop and unknown codes do nothing
            default: ;
        endcase
    end

    // Status is captured on the cycle after the message lands
    always_ff @(posedge spi_clk) begin
        if (msg_valid && has_resp) begin
            resp <= resp_next;
        end
    end

    // ==================================================
    // Sequencing
    // ==================================================

    // Drop listen as soon as a message arrives
    assign listen    = (state == ST_LISTEN) && !msg_valid;
    assign resp_load = (state == ST_TURNAROUND) && (ta_cnt == '0);

    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            state  <= ST_LISTEN;
            ta_cnt <= '0;
        end else begin
            case (state)
                ST_LISTEN: begin
                    if (msg_valid && has_resp) begin
                        state  <= ST_TURNAROUND;
                        ta_cnt <= TA_LAST;
                    end
                end
                ST_TURNAROUND: begin
                    if (ta_cnt == '0) begin
                        state <= ST_RESPOND;
                    end else begin
                        ta_cnt <= ta_cnt - 4'd1;
                    end
                end
                ST_RESPOND: begin
                    // Line belongs to the shifter until the last bit
                    if (resp_done) begin
                        state <= ST_LISTEN;
                    end
                end
                default: state <= ST_LISTEN;
            endcase
        end
    end

endmodule

// File: src/spi_msg_top.sv
`timescale 1ns/1ps

module spi_msg_top import spi_msg_pkg::*; #(
    parameter int TURNAROUND_CYCLES = 6
) (
    input  logic        spi_clk,
    input  logic        spi_rst_,
    input  logic        spi_data_in,
    output logic        spi_data_out,
    output logic        spi_data_oe,
    output led_t        led,
    output logic        img_rst_,
    output img_header_t img_header,
    output logic        capture_req,
    input  logic        capture_done,
    input  word_count_t capture_word_count
);

    // Receiver to controller
    msg_t    msg;
    logic    msg_valid;
    logic    listen;

    // Controller to registers and shifter
    reg_wr_t reg_wr;
    resp_t   resp;
    logic    resp_load;
    logic    resp_done;

    logic    capture_done_pending;

    spi_msg_receiver i_spi_msg_receiver (
        .spi_clk     (spi_clk),
        .spi_rst_    (spi_rst_),
        .spi_data_in (spi_data_in),
        .listen      (listen),
        .msg         (msg),
        .msg_valid   (msg_valid)
    );

    spi_msg_ctrl #(
        .TURNAROUND_CYCLES (TURNAROUND_CYCLES)
    ) i_spi_msg_ctrl (
        .spi_clk              (spi_clk),
        .spi_rst_             (spi_rst_),
        .msg                  (msg),
        .msg_valid            (msg_valid),
        .capture_done_pending (capture_done_pending),
        .capture_word_count   (capture_word_count),
        .resp_done            (resp_done),
        .listen               (listen),
        .reg_wr               (reg_wr),
        .resp                 (resp),
        .resp_load            (resp_load)
    );

    spi_resp_shifter i_spi_resp_shifter (
        .spi_clk      (spi_clk),
        .spi_rst_     (spi_rst_),
        .resp         (resp),
        .resp_load    (resp_load),
        .spi_data_out (spi_data_out),
        .spi_data_oe  (spi_data_oe),
        .resp_done    (resp_done)
    );

    img_cmd_regs i_img_cmd_regs (
        .spi_clk     (spi_clk),
        .spi_rst_    (spi_rst_),
        .reg_wr      (reg_wr),
        .led         (led),
        .img_rst_    (img_rst_),
        .img_header  (img_header),
        .capture_req (capture_req)
    );

    // The capture strobe doubles as the done-flag acknowledge
    capture_done_flag i_capture_done_flag (
        .spi_clk              (spi_clk),
        .spi_rst_             (spi_rst_),
        .capture_done         (capture_done),
        .ack                  (reg_wr.capture),
        .capture_done_pending (capture_done_pending)
    );

endmodule

// File: verification/spi_msg_properties.sv
`timescale 1ns/1ps

module spi_msg_properties import spi_msg_pkg::*; (
    input logic spi_clk,
    input logic spi_rst_,
    input logic resp_load,
    input logic spi_data_out,
    input logic spi_data_oe
);

    // Failed assertions so far
    int fail_count = 0;

    // ==================================================
    // Response framing
    // ==================================================

    // One full response, then the line is released
    property p_oe_length;
        @(posedge spi_clk) disable iff (!spi_rst_)
        resp_load |=> spi_data_oe [*RESP_LEN] ##1 !spi_data_oe;
    endproperty

    property p_out_low_when_idle;
        @(posedge spi_clk) disable iff (!spi_rst_)
        !spi_data_oe |-> !spi_data_out;
    endproperty

    // No new load while a response is still going out
    property p_no_load_while_busy;
        @(posedge spi_clk) disable iff (!spi_rst_)
        spi_data_oe |-> !resp_load;
    endproperty

    a_oe_length: assert property (p_oe_length) else begin
        $error("data_oe was not high for exactly %0d cycles after resp_load", RESP_LEN);
        fail_count++;
    end

    a_out_low_when_idle: assert property (p_out_low_when_idle) else begin
        $error("data_out is high while data_oe is low");
        fail_count++;
    end

    a_no_load_while_busy: assert property (p_no_load_while_busy) else begin
        $error("resp_load seen while data_oe is high");
        fail_count++;
    end

endmodule

bind spi_resp_shifter spi_msg_properties i_spi_msg_properties (
    .spi_clk      (spi_clk),
    .spi_rst_     (spi_rst_),
    .resp_load    (resp_load),
    .spi_data_out (spi_data_out),
    .spi_data_oe  (spi_data_oe)
);

// File: verification/spi_msg_tb.sv
`timescale 1ns/1ps

module spi_msg_tb import spi_msg_pkg::*; ();

    localparam int TURNAROUND_CYCLES = 6;
    localparam int NUM_ROWS          = 18;
    localparam int TIMEOUT_CYCLES    =
        (NUM_ROWS + 1) * (MSG_LEN + RESP_LEN + TURNAROUND_CYCLES + 20);

    typedef struct {
        string       name;
        logic [7:0]  code;
        msg_arg_t    arg;
        logic        has_resp;
        resp_t       exp_resp;
        led_t        exp_led;
        logic        exp_img_rst_;
        img_header_t exp_header;
        logic        exp_capture_req;
        logic        toggle_done;
        word_count_t word_count;
    } test_row_t;

    logic        spi_clk = 1'b0;
    logic        spi_rst_;
    logic        spi_data_in;
    logic        spi_data_out;
    logic        spi_data_oe;
    led_t        led;
    logic        img_rst_;
    img_header_t img_header;
    logic        capture_req;
    logic        capture_done;
    word_count_t capture_word_count;

    test_row_t   rows [NUM_ROWS];
    int          num_rows_built;
    logic [31:0] lcg_state;
    int          cycle_cnt = 0;

    // Expected peripheral state while the table is built
    led_t        led_m;
    logic        rst_m;
    msg_arg_t    hdr1_m;
    msg_arg_t    hdr2_m;
    logic        cap_m;
    logic        done_m;
    word_count_t wc_m;

    always #10 spi_clk = ~spi_clk;

    spi_msg_top #(
        .TURNAROUND_CYCLES (TURNAROUND_CYCLES)
    ) i_spi_msg_top (
        .spi_clk            (spi_clk),
        .spi_rst_           (spi_rst_),
        .spi_data_in        (spi_data_in),
        .spi_data_out       (spi_data_out),
        .spi_data_oe        (spi_data_oe),
        .led                (led),
        .img_rst_           (img_rst_),
        .img_header         (img_header),
        .capture_req        (capture_req),
        .capture_done       (capture_done),
        .capture_word_count (capture_word_count)
    );

    // ==================================================
    // Checking and random helpers
    // ==================================================
    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            stop_on_failure($sformatf("mismatch %s: expected %0h, actual %0h",
                                      name, expected, actual));
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic msg_arg_t random_arg();
        logic [31:0] hi;
        lcg_state = lcg_next(lcg_state);
        hi        = lcg_state;
        lcg_state = lcg_next(lcg_state);
        return {hi[23:0], lcg_state};
    endfunction

    // Drive one clock later, just after the rising edge
    task automatic next_cycle();
        @(posedge spi_clk);
        #1;
    endtask

    // ==================================================
    // Stimulus table
    // ==================================================
    task automatic add_row(input string name, input logic [7:0] code, input msg_arg_t arg,
                           input logic toggle_done, input word_count_t word_count);
        test_row_t r;
        if (toggle_done) begin
            done_m = 1'b1;
            wc_m   = word_count;
        end
        r.name        = name;
        r.code        = code;
        r.arg         = arg;
        r.toggle_done = toggle_done;
        r.word_count  = word_count;
        r.has_resp    = 1'b0;
        r.exp_resp    = '0;
        case (code)
            MSG_LED_SET:         led_m  = arg[3:0];
            MSG_IMG_RESET:       rst_m  = arg[0];
            MSG_IMG_SET_HEADER1: hdr1_m = arg;
            MSG_IMG_SET_HEADER2: hdr2_m = arg;
            MSG_IMG_CAPTURE: begin
                cap_m  = ~cap_m;
                done_m = 1'b0;
            end
            MSG_ECHO: begin
                r.has_resp = 1'b1;
                r.exp_resp = {arg, 8'h00};
            end
            MSG_IMG_CAPTURE_STATUS: begin
                r.has_resp = 1'b1;
                r.exp_resp = {done_m, 7'h00, wc_m, 32'h0000_0000};
            end
            default: ;
        endcase
        r.exp_led         = led_m;
        r.exp_img_rst_    = rst_m;
        r.exp_header      = {hdr1_m, hdr2_m, 16'h0000};
        r.exp_capture_req = cap_m;
        rows[num_rows_built] = r;
        num_rows_built++;
    endtask

    task automatic build_table();
        add_row("nop_idle",          MSG_NOP,                56'h0,              0, '0);
        add_row("echo_a",            MSG_ECHO,               random_arg(),       0, '0);
        add_row("echo_b",            MSG_ECHO,               random_arg(),       0, '0);
        add_row("nop_with_arg",      MSG_NOP,                random_arg(),       0, '0);
        add_row("led_set_a",         MSG_LED_SET,            56'ha5,             0, '0);
        add_row("img_reset_release", MSG_IMG_RESET,          56'h1,              0, '0);
        add_row("unknown_type",      8'h42,                  56'hff_ffff_fffe_fffe, 0, '0);
        add_row("unknown_resp_type", 8'hc3,                  56'hff_ffff_ffff_fffa, 0, '0);
        add_row("led_set_b",         MSG_LED_SET,            56'h12_3456_789a_bcde, 0, '0);
        add_row("img_reset_assert",  MSG_IMG_RESET,          56'hff_ffff_ffff_fffe, 0, '0);
        add_row("header1_a",         MSG_IMG_SET_HEADER1,    random_arg(),       0, '0);
        add_row("header2_a",         MSG_IMG_SET_HEADER2,    random_arg(),       0, '0);
        add_row("header1_b",         MSG_IMG_SET_HEADER1,    random_arg(),       0, '0);
        add_row("capture_start",     MSG_IMG_CAPTURE,        56'h0,              0, '0);
        add_row("status_busy",       MSG_IMG_CAPTURE_STATUS, 56'h0,              0, '0);
        add_row("status_done",       MSG_IMG_CAPTURE_STATUS, 56'h0,              1, 24'h3c5a96);
        add_row("capture_ack",       MSG_IMG_CAPTURE,        56'h0,              0, '0);
        add_row("status_cleared",    MSG_IMG_CAPTURE_STATUS, 56'h0,              0, '0);
    endtask

    // ==================================================
    // Host model
    // ==================================================
    task automatic run_row(input test_row_t r);
        logic [MSG_LEN-1:0] frame;
        resp_t              got;
        int                 waited;
        frame  = {r.code, r.arg};
        got    = '0;
        waited = 0;
        if (r.toggle_done) begin
            capture_done       = ~capture_done;
            capture_word_count = r.word_count;
            repeat (4) next_cycle();
        end
        // Start bit, then the frame MSB first
        spi_data_in = 1'b1;
        next_cycle();
        for (int i = MSG_LEN - 1; i >= 0; i--) begin
            spi_data_in = frame[i];
            next_cycle();
        end
        spi_data_in = 1'b0;
        while (!spi_data_oe && waited < TURNAROUND_CYCLES + 4) begin
            next_cycle();
            waited++;
        end
        if (r.has_resp) begin
            if (!spi_data_oe) begin
                stop_on_failure($sformatf("%s: data_oe did not rise within %0d cycles",
                                          r.name, TURNAROUND_CYCLES + 4));
            end
            check_value({r.name, " turnaround"}, TURNAROUND_CYCLES + 1, waited);
            for (int b = RESP_LEN - 1; b >= 0; b--) begin
                if (!spi_data_oe) begin
                    stop_on_failure($sformatf("%s: data_oe fell before response bit %0d",
                                              r.name, b));
                end
                got[b] = spi_data_out;
                next_cycle();
            end
            if (spi_data_oe) begin
                stop_on_failure($sformatf("%s: data_oe still high after %0d bits",
                                          r.name, RESP_LEN));
            end
            check_value({r.name, " response"}, r.exp_resp, got);
        end else if (spi_data_oe) begin
            stop_on_failure($sformatf("%s: response driven for a message without one",
                                      r.name));
        end
        repeat (4) next_cycle();
        check_value({r.name, " led"}, r.exp_led, led);
        check_value({r.name, " img_rst_"}, r.exp_img_rst_, img_rst_);
        check_value({r.name, " img_header"}, r.exp_header, img_header);
        check_value({r.name, " capture_req"}, r.exp_capture_req, capture_req);
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        spi_rst_           = 1'b0;
        spi_data_in        = 1'b0;
        capture_done       = 1'b0;
        capture_word_count = '0;
        lcg_state          = 32'he617;
        num_rows_built     = 0;
        led_m              = '0;
        rst_m              = 1'b0;
        hdr1_m             = '0;
        hdr2_m             = '0;
        cap_m              = 1'b0;
        done_m             = 1'b0;
        wc_m               = '0;
        build_table();

        repeat (5) @(posedge spi_clk);
        #1;
        spi_rst_ = 1'b1;
        next_cycle();

        // Everything idle after reset
        check_value("reset led", 0, led);
        check_value("reset img_rst_", 0, img_rst_);
        check_value("reset img_header", 0, img_header);
        check_value("reset capture_req", 0, capture_req);
        check_value("reset data_oe", 0, spi_data_oe);
        check_value("reset data_out", 0, spi_data_out);

        for (int i = 0; i < num_rows_built; i++) begin
            run_row(rows[i]);
        end

        if (i_spi_msg_top.i_spi_resp_shifter.i_spi_msg_properties.fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            stop_on_failure("response shifter assertions failed during the run");
        end
    end

    always @(posedge spi_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_on_failure($sformatf("run did not finish within %0d cycles",
                                      TIMEOUT_CYCLES));
        end
        if (i_spi_msg_top.i_spi_resp_shifter.i_spi_msg_properties.fail_count != 0) begin
            stop_on_failure("response shifter assertion failed");
        end
    end

endmodule

// File: spi_msg.f
src/spi_msg_pkg.sv
src/spi_msg_receiver.sv
src/spi_resp_shifter.sv
src/img_cmd_regs.sv
src/capture_done_flag.sv
src/spi_msg_ctrl.sv
src/spi_msg_top.sv
verification/spi_msg_properties.sv
verification/spi_msg_tb.sv
